// File: bench/serial_mem_tb.sv
// testbench for the serial memory loader
// table of commands, serial driver, tx frame decoder, byte model

`timescale 1ns/1ns
`default_nettype none

module serial_mem_tb;

    localparam int cpb    = 16;  // clock cycles per serial bit
    localparam int aw     = 10;
    localparam int n_rows = 12;

    typedef struct packed {
        serial_mem_pkg::byte_t cmd;
        logic [23:0]           addr;
        serial_mem_pkg::byte_t len;       // 0 stands for 256
        serial_mem_pkg::byte_t data_seed; // mixed into each random data byte
        logic                  bad_stop;  // first data byte goes out with a low stop bit
        logic [8:0]            n_reply;   // tx frames expected back
    } txn_t;

    logic clk;
    logic arst_n;
    logic rx;
    wire  tx;
    wire  frame_err;

    txn_t                  rows [n_rows];
    txn_t                  cur;
    serial_mem_pkg::byte_t model [2**aw]; // expected memory contents
    serial_mem_pkg::byte_t replies [$];   // decoded tx bytes of one command
    integer                rand_seed;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    fe_count = 0;
    int                    fe_start;
    int                    r;
    int                    i;

    serial_mem_top #(
        .cycles_per_bit (cpb),
        .addr_width     (aw)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .tx        (tx),
        .frame_err (frame_err)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (frame_err === 1'b1) fe_count++; // pulses seen on the pin
    end

    task automatic check_byte(input serial_mem_pkg::byte_t got,
                              input serial_mem_pkg::byte_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_table();
        rows[0]  = '{serial_mem_pkg::cmd_write, 24'h000010, 8'd4, 8'h00, 1'b0, 9'd0};
        rows[1]  = '{serial_mem_pkg::cmd_read,  24'h000010, 8'd4, 8'h00, 1'b0, 9'd4};
        rows[2]  = '{serial_mem_pkg::cmd_write, 24'h0003fe, 8'd4, 8'h5a, 1'b0, 9'd0};
        rows[3]  = '{serial_mem_pkg::cmd_read,  24'h000000, 8'd2, 8'h00, 1'b0, 9'd2};
        rows[4]  = '{serial_mem_pkg::cmd_write, 24'h07fc00, 8'd1, 8'h33, 1'b0, 9'd0};
        rows[5]  = '{serial_mem_pkg::cmd_read,  24'h000000, 8'd2, 8'h00, 1'b0, 9'd2};
        rows[6]  = '{serial_mem_pkg::cmd_write, 24'h000040, 8'd3, 8'h00, 1'b1, 9'd0};
        rows[7]  = '{serial_mem_pkg::cmd_read,  24'h000040, 8'd3, 8'h00, 1'b0, 9'd3};
        rows[8]  = '{8'h41,                     24'h000010, 8'd4, 8'h00, 1'b0, 9'd0};
        rows[9]  = '{serial_mem_pkg::cmd_read,  24'h000010, 8'd4, 8'h00, 1'b0, 9'd4};
        rows[10] = '{serial_mem_pkg::cmd_write, 24'h000200, 8'd0, 8'hc3, 1'b0, 9'd0};
        rows[11] = '{serial_mem_pkg::cmd_read,  24'h000200, 8'd0, 8'h00, 1'b0, 9'd256};
    endtask

    // entered and left 2 ns after a rising edge
    task automatic send_byte(input serial_mem_pkg::byte_t b, input logic bad);
        logic [9:0] frame;
        int         k;
        frame = {~bad, b, 1'b0}; // stop, data LSB first, start
        for (k = 0; k < 10; k++) begin
            rx = frame[k];
            repeat (cpb) @(posedge clk);
            #2;
        end
        if (bad) begin
            rx = 1'b1; // one idle bit to end the broken frame
            repeat (cpb) @(posedge clk);
            #2;
        end
    endtask

    // length byte and write data with the model following the wrap rule
    task automatic send_tail(input txn_t t);
        serial_mem_pkg::byte_t d;
        logic [aw-1:0]         a;
        int                    n;
        int                    k;
        send_byte(t.len, 1'b0);
        if (t.cmd == serial_mem_pkg::cmd_write) begin
            n = (t.len == 8'd0) ? 256 : int'(t.len);
            for (k = 0; k < n; k++) begin
                d = 8'($random(rand_seed)) ^ t.data_seed;
                a = t.addr[aw-1:0] + aw'(k);
                model[a] = d;
                if (k == 0 && t.bad_stop) send_byte(d, 1'b1);
                send_byte(d, 1'b0);
            end
        end
    endtask

    task automatic wait_start(output logic seen);
        int k;
        seen = 1'b0;
        for (k = 0; k < 40 * cpb; k++) begin
            @(negedge clk);
            if (tx === 1'b0) begin
                seen = 1'b1;
                break;
            end
        end
    endtask

    // called on the negedge where the start bit was first seen
    task automatic read_frame(output serial_mem_pkg::byte_t b);
        int k;
        repeat (cpb / 2 - 1) @(negedge clk);
        check_bit(tx, 1'b0, "tx start bit");
        for (k = 0; k < 8; k++) begin
            repeat (cpb) @(negedge clk);
            b[k] = tx;
        end
        repeat (cpb) @(negedge clk);
        check_bit(tx, 1'b1, "tx stop bit");
    endtask

    // decodes frames until the line stays idle for 40 bit periods
    task automatic collect_replies(input int n);
        logic                  seen;
        serial_mem_pkg::byte_t b;
        seen = 1'b1;
        while (seen) begin
            wait_start(seen);
            if (seen) begin
                read_frame(b);
                replies.push_back(b);
            end else if (replies.size() < n) begin
                other_errors++;
                $display("timed out waiting for a tx start bit, reply %0d of %0d",
                         replies.size(), n);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        rx        = 1'b1;
        rand_seed = 32'h8c1e98a7;
        load_table();
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;

        // idle line after reset
        for (i = 0; i < 20 * cpb; i++) begin
            @(negedge clk);
            check_bit(tx, 1'b1, "idle tx");
            check_bit(frame_err, 1'b0, "idle frame_err");
        end
        @(posedge clk);
        #2;

        for (r = 0; r < n_rows; r++) begin
            cur = rows[r];
            replies.delete();
            fe_start = fe_count;
            send_byte(cur.cmd, 1'b0);
            send_byte(cur.addr[23:16], 1'b0);
            send_byte(cur.addr[15:8], 1'b0);
            send_byte(cur.addr[7:0], 1'b0);
            fork
                send_tail(cur);
                collect_replies(int'(cur.n_reply));
            join
            check_bit(fe_count - fe_start == int'(cur.bad_stop), 1'b1,
                      $sformatf("row %0d frame_err pulse count", r));
            check_bit(replies.size() == int'(cur.n_reply), 1'b1,
                      $sformatf("row %0d reply count", r));
            for (i = 0; i < replies.size() && i < int'(cur.n_reply); i++) begin
                check_byte(replies[i], model[cur.addr[aw-1:0] + aw'(i)],
                           $sformatf("row %0d read byte %0d", r, i));
            end
            @(posedge clk);
            #2;
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/serial_mem_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/sram_store.sv
verilog/cmd_engine.sv
verilog/serial_mem_top.sv
bench/serial_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f \
    --top-module serial_mem_tb -o serial_mem_sim &&
./obj_dir/serial_mem_sim | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verilog/cmd_engine.sv
// command parser and transfer sequencer
// header capture, write stream into memory, read stream out to transmitter

`timescale 1ns/1ns
`default_nettype none

module cmd_engine #(
    parameter int addr_width = 19
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  serial_mem_pkg::byte_t rx_byte,
    input  logic                  rx_stb,
    input  serial_mem_pkg::byte_t mem_rdata,
    input  logic                  tx_busy,
    output logic [addr_width-1:0] mem_addr,
    output serial_mem_pkg::byte_t mem_wdata,
    output logic                  mem_we,
    output serial_mem_pkg::byte_t tx_byte,
    output logic                  tx_start
);

    localparam int hdr_w = 8 * serial_mem_pkg::addr_bytes;

    serial_mem_pkg::stage_t stage, stage_nxt;
    serial_mem_pkg::byte_t  cmd;
    logic [hdr_w-1:0]       addr_full; // upper bits beyond memory are dropped
    logic [8:0]             count;     // bytes left, up to 256
    logic                   last;
    logic                   step;      // one byte moved this cycle

    assign last      = (count == 9'd1);
    assign mem_addr  = addr_full[addr_width-1:0]; // wraps at top of memory
    assign mem_wdata = rx_byte;
    assign mem_we    = (stage == serial_mem_pkg::st_write) && rx_stb;
    assign tx_byte   = mem_rdata; // stable through st_send, address held
    assign tx_start  = (stage == serial_mem_pkg::st_send) && !tx_busy;
    assign step      = mem_we || tx_start;

    always_comb begin
        stage_nxt = stage;
        case (stage)
            serial_mem_pkg::st_cmd:      if (rx_stb) stage_nxt = serial_mem_pkg::st_addr_hi;
            serial_mem_pkg::st_addr_hi:  if (rx_stb) stage_nxt = serial_mem_pkg::st_addr_mid;
            serial_mem_pkg::st_addr_mid: if (rx_stb) stage_nxt = serial_mem_pkg::st_addr_lo;
            serial_mem_pkg::st_addr_lo:  if (rx_stb) stage_nxt = serial_mem_pkg::st_len;
            serial_mem_pkg::st_len: begin
                if (rx_stb) begin
                    if (cmd == serial_mem_pkg::cmd_write) begin
                        stage_nxt = serial_mem_pkg::st_write;
                    end else if (cmd == serial_mem_pkg::cmd_read) begin
                        stage_nxt = serial_mem_pkg::st_fetch;
                    end else begin
                        stage_nxt = serial_mem_pkg::st_cmd; // unknown command dropped
                    end
                end
            end
            serial_mem_pkg::st_write: begin
                if (rx_stb && last) stage_nxt = serial_mem_pkg::st_cmd;
            end
            serial_mem_pkg::st_fetch: stage_nxt = serial_mem_pkg::st_send;
            serial_mem_pkg::st_send: begin
                if (tx_start) begin
                    stage_nxt = last ? serial_mem_pkg::st_cmd : serial_mem_pkg::st_fetch;
                end
            end
            default: stage_nxt = serial_mem_pkg::st_cmd;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage <= serial_mem_pkg::st_cmd;
        end else begin
            stage <= stage_nxt;
        end
    end

    // header fields and transfer counters
    always_ff @(posedge clk) begin
        if (rx_stb) begin
            case (stage)
                serial_mem_pkg::st_cmd:      cmd <= rx_byte;
                serial_mem_pkg::st_addr_hi:  addr_full[23:16] <= rx_byte;
                serial_mem_pkg::st_addr_mid: addr_full[15:8]  <= rx_byte;
                serial_mem_pkg::st_addr_lo:  addr_full[7:0]   <= rx_byte;
                serial_mem_pkg::st_len:      count <= (rx_byte == 8'h00) ? 9'd256 : {1'b0, rx_byte};
                default: ;
            endcase
        end
        if (step) begin
            addr_full <= addr_full + 1'b1;
            count     <= count - 1'b1;
        end
    end

    a_we_in_write : assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_we |-> stage == serial_mem_pkg::st_write
    );

endmodule

`default_nettype wire

// File: verilog/serial_mem_pkg.sv
// shared byte type, command codes and engine stage encoding
// for the serial memory loader

`default_nettype none

package serial_mem_pkg;

    // payload word carried on every byte port
    typedef logic [7:0] byte_t;

    // command byte values
    localparam byte_t cmd_write = 8'h57; // 'W'
    localparam byte_t cmd_read  = 8'h52; // 'R'

    // address bytes in a command header, high byte first
    localparam int addr_bytes = 3;

    // engine stages, header bytes first, then transfer
    typedef enum logic [2:0] {
        st_cmd      = 3'd0, // waiting for command byte
        st_addr_hi  = 3'd1, // address bits 23:16
        st_addr_mid = 3'd2, // address bits 15:8
        st_addr_lo  = 3'd3, // address bits 7:0
        st_len      = 3'd4, // length byte, 0 means 256
        st_write    = 3'd5, // storing incoming data bytes
        st_fetch    = 3'd6, // memory read in flight
        st_send     = 3'd7  // handing byte to transmitter
    } stage_t;

endpackage

`default_nettype wire

// File: verilog/serial_mem_top.sv
// top level of the serial memory loader
// receiver and memory side by side, engine between them and the transmitter

`timescale 1ns/1ns
`default_nettype none

module serial_mem_top #(
    parameter int cycles_per_bit = 2500,
    parameter int addr_width     = 19
) (
    input  wire  clk,
    input  wire  arst_n,
    input  logic rx,
    output logic tx,
    output logic frame_err
);

    serial_mem_pkg::byte_t rx_byte;
    logic                  rx_stb;
    logic [addr_width-1:0] mem_addr;
    serial_mem_pkg::byte_t mem_wdata;
    serial_mem_pkg::byte_t mem_rdata;
    logic                  mem_we;
    serial_mem_pkg::byte_t tx_byte;
    logic                  tx_start;
    logic                  tx_busy;

    uart_rx #(
        .cycles_per_bit(cycles_per_bit)
    ) u_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .rx_stb    (rx_stb),
        .frame_err (frame_err) // straight to the pin
    );

    sram_store #(
        .addr_width(addr_width)
    ) u_mem (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    cmd_engine #(
        .addr_width(addr_width)
    ) u_engine (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_byte   (rx_byte),
        .rx_stb    (rx_stb),
        .mem_rdata (mem_rdata),
        .tx_busy   (tx_busy),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start)
    );

    uart_tx #(
        .cycles_per_bit(cycles_per_bit)
    ) u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: verilog/sram_store.sv
// single-port byte memory
// synchronous write, registered read

`timescale 1ns/1ns
`default_nettype none

module sram_store #(
    parameter int addr_width = 19
) (
    input  wire                     clk,
    input  logic [addr_width-1:0]   mem_addr,
    input  serial_mem_pkg::byte_t   mem_wdata,
    input  logic                    mem_we,
    output serial_mem_pkg::byte_t   mem_rdata
);

    localparam int depth = 2 ** addr_width;

    serial_mem_pkg::byte_t mem [depth]; // stands in for external sram

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr]; // read data one cycle behind address
    end

    a_addr_known : assert property (
        @(posedge clk)
        mem_we |-> !$isunknown(mem_addr)
    );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// serial receiver with mid-bit sampling
// emits a byte strobe per good frame or a framing error pulse

`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
    parameter int cycles_per_bit = 2500
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  logic                  rx,
    output serial_mem_pkg::byte_t rx_byte,
    output logic                  rx_stb,
    output logic                  frame_err
);

    localparam int cnt_w = $clog2(cycles_per_bit);
    // first wait lands near mid start bit after 4 cycles of sync and edge detect
    localparam logic [cnt_w-1:0] half_load = cnt_w'(cycles_per_bit / 2 - 4);
    localparam logic [cnt_w-1:0] full_load = cnt_w'(cycles_per_bit - 1);

    logic             rx_s1, rx_s2, rx_s3; // sync chain plus edge history
    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic [3:0]       bit_idx;             // 0 start, 1..8 data, 9 stop
    logic             start_edge;

    assign start_edge = rx_s3 && !rx_s2; // falling edge only so a low line does not retrigger

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_s3 <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_s3 <= rx_s2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_stb    <= 1'b0; // single-cycle pulses
            frame_err <= 1'b0;
            if (!busy) begin
                if (start_edge) begin
                    busy    <= 1'b1;
                    cnt     <= half_load;
                    bit_idx <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt <= full_load;
                if (bit_idx == 4'd0) begin
                    if (rx_s2) begin
                        busy <= 1'b0; // line back high before mid start bit
                    end
                    bit_idx <= 4'd1;
                end else if (bit_idx == 4'd9) begin
                    busy      <= 1'b0;
                    rx_stb    <= rx_s2;
                    frame_err <= !rx_s2;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // data shifts in LSB first
    always_ff @(posedge clk) begin
        if (busy && cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            rx_byte <= {rx_s2, rx_byte[7:1]};
        end
    end

    a_rx_exclusive : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(rx_stb && frame_err)
    );

    a_rx_one_cycle : assert property (
        @(posedge clk) disable iff (!arst_n)
        (rx_stb || frame_err) |=> !(rx_stb || frame_err)
    );

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// serial transmitter, one 10-bit frame per start pulse
// start bit, 8 data bits LSB first, stop bit

`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int cycles_per_bit = 2500
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  serial_mem_pkg::byte_t tx_byte,
    input  logic                  tx_start,
    output logic                  tx,
    output logic                  tx_busy
);

    localparam int cnt_w = $clog2(cycles_per_bit);
    localparam logic [cnt_w-1:0] full_load = cnt_w'(cycles_per_bit - 1);

    logic [9:0]       frame;     // bit 0 is on the line
    logic [cnt_w-1:0] cnt;
    logic [3:0]       bits_left;

    assign tx = frame[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame     <= '1; // idle line high
            cnt       <= '0;
            bits_left <= '0;
            tx_busy   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame     <= {1'b1, tx_byte, 1'b0};
                cnt       <= full_load;
                bits_left <= 4'd9;
                tx_busy   <= 1'b1;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (bits_left == 4'd0) begin
            tx_busy <= 1'b0; // stop bit fully sent
        end else begin
            frame     <= {1'b1, frame[9:1]}; // shift in idle level
            cnt       <= full_load;
            bits_left <= bits_left - 1'b1;
        end
    end

    // the engine must wait for the frame in flight
    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy
    );

endmodule

`default_nettype wire
